// ==== hdl/bank_sram_controller.sv ====
`default_nettype none

module bank_sram_controller
  import l2_data_pkg::*;
(
  input  wire               clk_i,
  input  wire               rst_i,
  // issue port
  input  wire               req_valid_i,
  output logic              req_ready_o,
  input  wire opcode_t      req_opcode_i,
  input  wire chan_t        req_channel_i,
  input  wire set_way_off_t req_set_way_off_i,
  input  wire wbuf_id_t     req_wbuf_id_i,
  input  wire rob_t         req_rob_i,
  input  wire line_state_t  req_state0_i,
  input  wire line_state_t  req_state1_i,
  input  wire data_t        req_fill0_i,
  input  wire data_t        req_fill1_i,
  // write buffer
  output logic              wbuf_req_valid_o,
  input  wire               wbuf_req_ready_i,
  output chan_t             wbuf_req_channel_o,
  output wbuf_id_t          wbuf_req_id_o,
  input  wire               wbuf_rtn_valid_i,
  input  wire data_t        wbuf_rtn_data_i,
  // crossbar response
  xbar_rsp_if.bank          rsp
);

  logic         op_write;
  logic         op_read;
  logic         op_lf;
  logic         sel_off;
  line_state_t  unsel_state;
  logic         unsel_empty;
  logic         lf_once;
  logic         lf_twice;
  logic         lf_off;
  data_t        sel_fill;
  data_t        lf_fill;

  logic [1:0]   step_q;
  logic         step_incr;
  logic [1:0]   wr_cnt_q;
  logic         lf_wr;
  logic         sent_q;
  logic         hold_valid_q;
  data_t        hold_q;
  logic         hold_push;

  logic         rsp_valid;
  logic         rsp_kick;
  logic         wbuf_kick;
  logic         rd_issue;
  logic         wr_commit;
  logic         rd_done;
  logic         lf_done;
  logic         req_done;

  logic         ram_en;
  logic         ram_we;
  set_way_off_t ram_addr;
  data_t        ram_wdata;
  data_t        ram_rdata;

  // --------------------------------------------------
  // request decode
  // --------------------------------------------------
  assign op_write = req_opcode_i == OP_WRITE;
  assign op_read  = req_opcode_i == OP_READ;
  assign op_lf    = req_opcode_i == OP_READ_LINEFILL;

  assign sel_off     = req_set_way_off_i[0];
  assign unsel_state = sel_off ? req_state0_i : req_state1_i;
  assign unsel_empty = unsel_state == LS_EMPTY;

  // refill the other half too when it holds nothing
  assign lf_once  = op_lf & ~unsel_empty;
  assign lf_twice = op_lf & unsel_empty;

  assign sel_fill = sel_off ? req_fill1_i : req_fill0_i;

  // second linefill write goes to the other half
  assign lf_off  = wr_cnt_q[0] ? ~sel_off : sel_off;
  assign lf_fill = lf_off ? req_fill1_i : req_fill0_i;

  // --------------------------------------------------
  // write buffer fetch
  // --------------------------------------------------
  assign wbuf_req_valid_o   = req_valid_i & op_write & (step_q == 2'd0);
  assign wbuf_req_channel_o = req_channel_i;
  assign wbuf_req_id_o      = req_wbuf_id_i;
  assign wbuf_kick          = wbuf_req_valid_o & wbuf_req_ready_i;

  // --------------------------------------------------
  // crossbar response
  // --------------------------------------------------
  assign rsp_valid = req_valid_i
                   & ((op_read & (step_q == 2'd1)) | (op_lf & ~sent_q));
  assign rsp_kick  = rsp_valid & rsp.ready;

  assign rsp.valid   = rsp_valid;
  assign rsp.channel = req_channel_i;
  assign rsp.rob     = req_rob_i;
  assign rsp.data    = op_lf        ? sel_fill
                     : hold_valid_q ? hold_q
                     :                ram_rdata;

  // linefill data already handed over, waiting on the writes
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      sent_q <= 1'b0;
    end else if (req_done) begin
      sent_q <= 1'b0;
    end else if (op_lf && rsp_kick) begin
      sent_q <= 1'b1;
    end
  end

  // read holding buffer, filled on the first stalled cycle
  assign hold_push = req_valid_i & op_read & (step_q == 2'd1)
                   & ~hold_valid_q & ~rsp_kick;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      hold_valid_q <= 1'b0;
    end else if (req_done) begin
      hold_valid_q <= 1'b0;
    end else if (hold_push) begin
      hold_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (hold_push) begin
      hold_q <= ram_rdata;
    end
  end

  // --------------------------------------------------
  // sequencing and completion
  // --------------------------------------------------
  assign rd_issue  = req_valid_i & op_read & (step_q == 2'd0);
  assign wr_commit = req_valid_i & op_write & wbuf_rtn_valid_i;
  assign step_incr = wbuf_kick | rd_issue;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      step_q <= 2'd0;
    end else if (req_done) begin
      step_q <= 2'd0;
    end else if (step_incr) begin
      step_q <= step_q + 2'd1;
    end
  end

  // one write for a single half, two when filling the whole line
  assign lf_wr = req_valid_i
               & ((lf_once & (wr_cnt_q == 2'd0)) | (lf_twice & (wr_cnt_q <= 2'd1)));

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      wr_cnt_q <= 2'd0;
    end else if (req_done) begin
      wr_cnt_q <= 2'd0;
    end else if (lf_wr) begin
      wr_cnt_q <= wr_cnt_q + 2'd1;
    end
  end

  assign rd_done = op_read & rsp_kick;
  // last write may coincide with completion
  assign lf_done = req_valid_i & op_lf
                 & (~lf_twice | (wr_cnt_q != 2'd0))
                 & (rsp_kick | sent_q);

  assign req_done    = wr_commit | rd_done | lf_done;
  assign req_ready_o = req_done;

  // --------------------------------------------------
  // data RAM
  // --------------------------------------------------
  assign ram_en    = lf_wr | rd_issue | wr_commit;
  assign ram_we    = lf_wr | wr_commit;
  assign ram_addr  = {req_set_way_off_i[IDX_W-1:1], op_lf ? lf_off : sel_off};
  assign ram_wdata = op_write ? wbuf_rtn_data_i : lf_fill;

  data_ram_sp data_ram_inst (
    .clk_i   (clk_i),
    .en_i    (ram_en),
    .we_i    (ram_we),
    .addr_i  (ram_addr),
    .wdata_i (ram_wdata),
    .rdata_o (ram_rdata)
  );

endmodule

`default_nettype wire

// ==== hdl/data_ram_sp.sv ====
`default_nettype none

module data_ram_sp
  import l2_data_pkg::*;
(
  input  wire               clk_i,
  input  wire               en_i,
  input  wire               we_i,
  input  wire set_way_off_t addr_i,
  input  wire data_t        wdata_i,
  output data_t             rdata_o
);

  // behavioral model of a 128 x 128 macro
  data_t mem_q [RAM_DEPTH];

  // one access per cycle, read data lands after the edge
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/l2_data_banks.sv ====
`default_nettype none

module l2_data_banks
  import l2_data_pkg::*;
(
  input  wire               clk_i,
  input  wire               rst_i,
  // bank 0 issue
  input  wire               b0_req_valid_i,
  output logic              b0_req_ready_o,
  input  wire opcode_t      b0_req_opcode_i,
  input  wire chan_t        b0_req_channel_i,
  input  wire set_way_off_t b0_req_set_way_off_i,
  input  wire wbuf_id_t     b0_req_wbuf_id_i,
  input  wire rob_t         b0_req_rob_i,
  input  wire line_state_t  b0_req_state0_i,
  input  wire line_state_t  b0_req_state1_i,
  input  wire data_t        b0_req_fill0_i,
  input  wire data_t        b0_req_fill1_i,
  // bank 0 write buffer
  output logic              b0_wbuf_req_valid_o,
  input  wire               b0_wbuf_req_ready_i,
  output chan_t             b0_wbuf_req_channel_o,
  output wbuf_id_t          b0_wbuf_req_id_o,
  input  wire               b0_wbuf_rtn_valid_i,
  input  wire data_t        b0_wbuf_rtn_data_i,
  // bank 1 issue
  input  wire               b1_req_valid_i,
  output logic              b1_req_ready_o,
  input  wire opcode_t      b1_req_opcode_i,
  input  wire chan_t        b1_req_channel_i,
  input  wire set_way_off_t b1_req_set_way_off_i,
  input  wire wbuf_id_t     b1_req_wbuf_id_i,
  input  wire rob_t         b1_req_rob_i,
  input  wire line_state_t  b1_req_state0_i,
  input  wire line_state_t  b1_req_state1_i,
  input  wire data_t        b1_req_fill0_i,
  input  wire data_t        b1_req_fill1_i,
  // bank 1 write buffer
  output logic              b1_wbuf_req_valid_o,
  input  wire               b1_wbuf_req_ready_i,
  output chan_t             b1_wbuf_req_channel_o,
  output wbuf_id_t          b1_wbuf_req_id_o,
  input  wire               b1_wbuf_rtn_valid_i,
  input  wire data_t        b1_wbuf_rtn_data_i,
  // merged crossbar response
  output logic              xbar_valid_o,
  input  wire               xbar_ready_i,
  output bank_t             xbar_bank_o,
  output chan_t             xbar_channel_o,
  output rob_t              xbar_rob_o,
  output data_t             xbar_data_o
);

  xbar_rsp_if rsp0_if ();
  xbar_rsp_if rsp1_if ();

  // --------------------------------------------------
  // banks
  // --------------------------------------------------
  bank_sram_controller bank0_inst (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .req_valid_i        (b0_req_valid_i),
    .req_ready_o        (b0_req_ready_o),
    .req_opcode_i       (b0_req_opcode_i),
    .req_channel_i      (b0_req_channel_i),
    .req_set_way_off_i  (b0_req_set_way_off_i),
    .req_wbuf_id_i      (b0_req_wbuf_id_i),
    .req_rob_i          (b0_req_rob_i),
    .req_state0_i       (b0_req_state0_i),
    .req_state1_i       (b0_req_state1_i),
    .req_fill0_i        (b0_req_fill0_i),
    .req_fill1_i        (b0_req_fill1_i),
    .wbuf_req_valid_o   (b0_wbuf_req_valid_o),
    .wbuf_req_ready_i   (b0_wbuf_req_ready_i),
    .wbuf_req_channel_o (b0_wbuf_req_channel_o),
    .wbuf_req_id_o      (b0_wbuf_req_id_o),
    .wbuf_rtn_valid_i   (b0_wbuf_rtn_valid_i),
    .wbuf_rtn_data_i    (b0_wbuf_rtn_data_i),
    .rsp                (rsp0_if.bank)
  );

  bank_sram_controller bank1_inst (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .req_valid_i        (b1_req_valid_i),
    .req_ready_o        (b1_req_ready_o),
    .req_opcode_i       (b1_req_opcode_i),
    .req_channel_i      (b1_req_channel_i),
    .req_set_way_off_i  (b1_req_set_way_off_i),
    .req_wbuf_id_i      (b1_req_wbuf_id_i),
    .req_rob_i          (b1_req_rob_i),
    .req_state0_i       (b1_req_state0_i),
    .req_state1_i       (b1_req_state1_i),
    .req_fill0_i        (b1_req_fill0_i),
    .req_fill1_i        (b1_req_fill1_i),
    .wbuf_req_valid_o   (b1_wbuf_req_valid_o),
    .wbuf_req_ready_i   (b1_wbuf_req_ready_i),
    .wbuf_req_channel_o (b1_wbuf_req_channel_o),
    .wbuf_req_id_o      (b1_wbuf_req_id_o),
    .wbuf_rtn_valid_i   (b1_wbuf_rtn_valid_i),
    .wbuf_rtn_data_i    (b1_wbuf_rtn_data_i),
    .rsp                (rsp1_if.bank)
  );

  // --------------------------------------------------
  // response merge
  // --------------------------------------------------
  xbar_rsp_arbiter xbar_rsp_arbiter_inst (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .bank0          (rsp0_if.arb),
    .bank1          (rsp1_if.arb),
    .xbar_valid_o   (xbar_valid_o),
    .xbar_ready_i   (xbar_ready_i),
    .xbar_bank_o    (xbar_bank_o),
    .xbar_channel_o (xbar_channel_o),
    .xbar_rob_o     (xbar_rob_o),
    .xbar_data_o    (xbar_data_o)
  );

endmodule

`default_nettype wire

// ==== hdl/l2_data_pkg.sv ====
`default_nettype none

package l2_data_pkg;

  // --------------------------------------------------
  // widths and sizes
  // --------------------------------------------------
  localparam int DATA_W    = 128;
  localparam int IDX_W     = 7;
  localparam int RAM_DEPTH = 128;
  localparam int NUM_BANKS = 2;
  localparam int BANK_W    = $clog2(NUM_BANKS);

  // half-line payload
  typedef logic [DATA_W-1:0] data_t;
  // {set, way} in [6:1], half-line offset in [0]
  typedef logic [IDX_W-1:0]  set_way_off_t;
  typedef logic [1:0]        chan_t;
  typedef logic [2:0]        rob_t;
  typedef logic [7:0]        wbuf_id_t;
  typedef logic [2:0]        opcode_t;
  typedef logic [1:0]        line_state_t;
  typedef logic [BANK_W-1:0] bank_t;

  // --------------------------------------------------
  // request opcodes
  // --------------------------------------------------
  localparam opcode_t OP_WRITE         = 3'd0;
  localparam opcode_t OP_READ          = 3'd1;
  localparam opcode_t OP_READ_LINEFILL = 3'd2;

  // per-offset line state
  localparam line_state_t LS_EMPTY = 2'd0;
  localparam line_state_t LS_DIRTY = 2'd1;
  localparam line_state_t LS_SYNC  = 2'd2;

endpackage

`default_nettype wire

// ==== hdl/xbar_rsp_arbiter.sv ====
`default_nettype none

module xbar_rsp_arbiter
  import l2_data_pkg::*;
(
  input  wire      clk_i,
  input  wire      rst_i,
  xbar_rsp_if.arb  bank0,
  xbar_rsp_if.arb  bank1,
  output logic     xbar_valid_o,
  input  wire      xbar_ready_i,
  output bank_t    xbar_bank_o,
  output chan_t    xbar_channel_o,
  output rob_t     xbar_rob_o,
  output data_t    xbar_data_o
);

  // bank that wins a tie next time
  bank_t prio_q;
  logic  lock_q;
  bank_t lock_bank_q;
  bank_t grant;

  // --------------------------------------------------
  // grant select
  // --------------------------------------------------
  always_comb begin
    if (lock_q) begin
      grant = lock_bank_q;
    end else if (bank0.valid && bank1.valid) begin
      grant = prio_q;
    end else if (bank1.valid) begin
      grant = bank_t'(1);
    end else begin
      grant = bank_t'(0);
    end
  end

  // output mux
  assign xbar_valid_o   = (grant == bank_t'(1)) ? bank1.valid   : bank0.valid;
  assign xbar_channel_o = (grant == bank_t'(1)) ? bank1.channel : bank0.channel;
  assign xbar_rob_o     = (grant == bank_t'(1)) ? bank1.rob     : bank0.rob;
  assign xbar_data_o    = (grant == bank_t'(1)) ? bank1.data    : bank0.data;
  assign xbar_bank_o    = grant;

  // only the granted bank sees ready
  assign bank0.ready = xbar_ready_i & (grant == bank_t'(0));
  assign bank1.ready = xbar_ready_i & (grant == bank_t'(1));

  // --------------------------------------------------
  // lock under back-pressure, rotate on accept
  // --------------------------------------------------
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      prio_q      <= bank_t'(0);
      lock_q      <= 1'b0;
      lock_bank_q <= bank_t'(0);
    end else if (xbar_valid_o && !xbar_ready_i) begin
      lock_q      <= 1'b1;
      lock_bank_q <= grant;
    end else if (xbar_valid_o) begin
      lock_q <= 1'b0;
      prio_q <= ~grant;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/xbar_rsp_if.sv ====
`default_nettype none

// one bank's response toward the crossbar
interface xbar_rsp_if
  import l2_data_pkg::*;
();

  logic  valid;
  logic  ready;
  chan_t channel;
  rob_t  rob;
  data_t data;

  // payload holds while valid and not ready
  modport bank (
    output valid,
    output channel,
    output rob,
    output data,
    input  ready
  );

  modport arb (
    input  valid,
    input  channel,
    input  rob,
    input  data,
    output ready
  );

endinterface

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the L2 data bank testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module l2_data_tb -f src.f -o l2_data_sim || { echo "build failed"; exit 1; }

out="$(./obj_dir/l2_data_sim +verilator+error+limit+100)"
echo "$out"
echo "$out" | grep -qx '>>> PASS' && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== src.f ====
hdl/l2_data_pkg.sv
hdl/xbar_rsp_if.sv
hdl/data_ram_sp.sv
hdl/bank_sram_controller.sv
hdl/xbar_rsp_arbiter.sv
hdl/l2_data_banks.sv
tests/l2_data_chk.sv
tests/l2_data_tb.sv

// ==== tests/l2_data_chk.sv ====
`default_nettype none

module l2_data_chk
  import l2_data_pkg::*;
(
  input wire           clk_i,
  input wire           rst_i,
  input wire           b0_req_valid_i,
  input wire           b0_req_ready_i,
  input wire           b1_req_valid_i,
  input wire           b1_req_ready_i,
  input wire           b0_wbuf_req_valid_i,
  input wire           b0_wbuf_req_ready_i,
  input wire chan_t    b0_wbuf_req_channel_i,
  input wire wbuf_id_t b0_wbuf_req_id_i,
  input wire           b1_wbuf_req_valid_i,
  input wire           b1_wbuf_req_ready_i,
  input wire chan_t    b1_wbuf_req_channel_i,
  input wire wbuf_id_t b1_wbuf_req_id_i,
  input wire           xbar_valid_i,
  input wire           xbar_ready_i,
  input wire bank_t    xbar_bank_i,
  input wire chan_t    xbar_channel_i,
  input wire rob_t     xbar_rob_i,
  input wire data_t    xbar_data_i
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_cnt = 0;

  // --------------------------------------------------
  // quiet during and right after reset
  // --------------------------------------------------
  a_reset_quiet: assert property (@(posedge clk_i)
    (rst_i || $fell(rst_i)) |-> !xbar_valid_i && !b0_req_ready_i && !b1_req_ready_i
      && !b0_wbuf_req_valid_i && !b1_wbuf_req_valid_i)
    else begin $error("output active in or right after reset"); fail_cnt++; end

  // crossbar payload holds under stall
  a_xbar_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    xbar_valid_i && !xbar_ready_i |=> xbar_valid_i && $stable(xbar_bank_i)
      && $stable(xbar_channel_i) && $stable(xbar_rob_i) && $stable(xbar_data_i))
    else begin $error("crossbar response changed while stalled"); fail_cnt++; end

  // --------------------------------------------------
  // write buffer request holds until accepted
  // --------------------------------------------------
  a_wbuf0_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    b0_wbuf_req_valid_i && !b0_wbuf_req_ready_i |=> b0_wbuf_req_valid_i
      && $stable(b0_wbuf_req_channel_i) && $stable(b0_wbuf_req_id_i))
    else begin $error("bank 0 write buffer request dropped or changed"); fail_cnt++; end

  a_wbuf1_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    b1_wbuf_req_valid_i && !b1_wbuf_req_ready_i |=> b1_wbuf_req_valid_i
      && $stable(b1_wbuf_req_channel_i) && $stable(b1_wbuf_req_id_i))
    else begin $error("bank 1 write buffer request dropped or changed"); fail_cnt++; end

  // completion only for a live request
  a_ready0_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    b0_req_ready_i |-> b0_req_valid_i)
    else begin $error("bank 0 ready without request"); fail_cnt++; end

  a_ready1_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    b1_req_ready_i |-> b1_req_valid_i)
    else begin $error("bank 1 ready without request"); fail_cnt++; end

endmodule

bind l2_data_banks l2_data_chk l2_data_chk_inst (
  .clk_i                 (clk_i),
  .rst_i                 (rst_i),
  .b0_req_valid_i        (b0_req_valid_i),
  .b0_req_ready_i        (b0_req_ready_o),
  .b1_req_valid_i        (b1_req_valid_i),
  .b1_req_ready_i        (b1_req_ready_o),
  .b0_wbuf_req_valid_i   (b0_wbuf_req_valid_o),
  .b0_wbuf_req_ready_i   (b0_wbuf_req_ready_i),
  .b0_wbuf_req_channel_i (b0_wbuf_req_channel_o),
  .b0_wbuf_req_id_i      (b0_wbuf_req_id_o),
  .b1_wbuf_req_valid_i   (b1_wbuf_req_valid_o),
  .b1_wbuf_req_ready_i   (b1_wbuf_req_ready_i),
  .b1_wbuf_req_channel_i (b1_wbuf_req_channel_o),
  .b1_wbuf_req_id_i      (b1_wbuf_req_id_o),
  .xbar_valid_i          (xbar_valid_o),
  .xbar_ready_i          (xbar_ready_i),
  .xbar_bank_i           (xbar_bank_o),
  .xbar_channel_i        (xbar_channel_o),
  .xbar_rob_i            (xbar_rob_o),
  .xbar_data_i           (xbar_data_o)
);

`default_nettype wire

// ==== tests/l2_data_tb.sv ====
`default_nettype none

module l2_data_tb
  import l2_data_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_WAIT = 300;

  logic         clk;
  logic         rst;
  logic         req_valid [2];
  logic         req_ready [2];
  opcode_t      req_op [2];
  chan_t        req_ch [2];
  set_way_off_t req_idx [2];
  wbuf_id_t     req_wbid [2];
  rob_t         req_rob [2];
  line_state_t  req_s0 [2];
  line_state_t  req_s1 [2];
  data_t        req_f0 [2];
  data_t        req_f1 [2];
  logic         wb_req_valid [2];
  logic         wb_req_ready [2];
  chan_t        wb_req_ch [2];
  wbuf_id_t     wb_req_id [2];
  logic         wb_rtn_valid [2];
  data_t        wb_rtn_data [2];
  logic         wb_seen [2];
  int           wb_state [2];
  int           wb_cnt [2];
  wbuf_id_t     wb_id [2];
  logic         xbar_valid;
  logic         xbar_ready;
  bank_t        xbar_bank;
  chan_t        xbar_ch;
  rob_t         xbar_rob;
  data_t        xbar_data;

  int           seed = 32'h8b28f4c0;
  int           err_cnt = 0;
  int           tmo_cnt = 0;
  int           rsp_cnt = 0;
  // reference contents and expected {channel, rob, data} per bank
  data_t        ref_mem [2][RAM_DEPTH];
  logic [132:0] exp_q [2][$];

  l2_data_banks l2_data_banks_inst (
    .clk_i (clk), .rst_i (rst),
    .b0_req_valid_i (req_valid[0]), .b0_req_ready_o (req_ready[0]),
    .b0_req_opcode_i (req_op[0]), .b0_req_channel_i (req_ch[0]),
    .b0_req_set_way_off_i (req_idx[0]), .b0_req_wbuf_id_i (req_wbid[0]),
    .b0_req_rob_i (req_rob[0]), .b0_req_state0_i (req_s0[0]), .b0_req_state1_i (req_s1[0]),
    .b0_req_fill0_i (req_f0[0]), .b0_req_fill1_i (req_f1[0]),
    .b0_wbuf_req_valid_o (wb_req_valid[0]), .b0_wbuf_req_ready_i (wb_req_ready[0]),
    .b0_wbuf_req_channel_o (wb_req_ch[0]), .b0_wbuf_req_id_o (wb_req_id[0]),
    .b0_wbuf_rtn_valid_i (wb_rtn_valid[0]), .b0_wbuf_rtn_data_i (wb_rtn_data[0]),
    .b1_req_valid_i (req_valid[1]), .b1_req_ready_o (req_ready[1]),
    .b1_req_opcode_i (req_op[1]), .b1_req_channel_i (req_ch[1]),
    .b1_req_set_way_off_i (req_idx[1]), .b1_req_wbuf_id_i (req_wbid[1]),
    .b1_req_rob_i (req_rob[1]), .b1_req_state0_i (req_s0[1]), .b1_req_state1_i (req_s1[1]),
    .b1_req_fill0_i (req_f0[1]), .b1_req_fill1_i (req_f1[1]),
    .b1_wbuf_req_valid_o (wb_req_valid[1]), .b1_wbuf_req_ready_i (wb_req_ready[1]),
    .b1_wbuf_req_channel_o (wb_req_ch[1]), .b1_wbuf_req_id_o (wb_req_id[1]),
    .b1_wbuf_rtn_valid_i (wb_rtn_valid[1]), .b1_wbuf_rtn_data_i (wb_rtn_data[1]),
    .xbar_valid_o (xbar_valid), .xbar_ready_i (xbar_ready), .xbar_bank_o (xbar_bank),
    .xbar_channel_o (xbar_ch), .xbar_rob_o (xbar_rob), .xbar_data_o (xbar_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // --------------------------------------------------
  // request driver and reference model
  // --------------------------------------------------
  task automatic issue_req(input int b, input opcode_t op, input set_way_off_t idx,
                           input line_state_t s0, input line_state_t s1);
    wbuf_id_t wbid;
    chan_t    ch;
    rob_t     rob;
    data_t    f0;
    data_t    f1;
    logic     sel;
    int       n;
    wbid = wbuf_id_t'($random(seed));
    ch   = chan_t'($random(seed));
    rob  = rob_t'($random(seed));
    f0   = {$random(seed), $random(seed), $random(seed), $random(seed)};
    f1   = {$random(seed), $random(seed), $random(seed), $random(seed)};
    sel  = idx[0];
    if (op == OP_WRITE) begin
      ref_mem[b][idx] = {16{wbid}};
    end else if (op == OP_READ) begin
      exp_q[b].push_back({ch, rob, ref_mem[b][idx]});
    end else begin
      exp_q[b].push_back({ch, rob, sel ? f1 : f0});
      ref_mem[b][idx] = sel ? f1 : f0;
      // whole line refilled when the other half is empty
      if ((sel ? s0 : s1) == LS_EMPTY) begin
        ref_mem[b][idx ^ 7'd1] = sel ? f0 : f1;
      end
    end
    @(negedge clk);
    req_valid[b] = 1'b1;
    req_op[b]    = op;
    req_idx[b]   = idx;
    req_wbid[b]  = wbid;
    req_ch[b]    = ch;
    req_rob[b]   = rob;
    req_s0[b]    = s0;
    req_s1[b]    = s1;
    req_f0[b]    = f0;
    req_f1[b]    = f1;
    n = 0;
    @(posedge clk);
    while (!req_ready[b] && n < MAX_WAIT) begin
      @(posedge clk);
      n++;
    end
    if (!req_ready[b]) begin
      $display("timeout: bank %0d request never completed", b);
      tmo_cnt++;
    end
    @(negedge clk);
    req_valid[b] = 1'b0;
  endtask

  task automatic directed_seq(input int b);
    issue_req(b, OP_WRITE, 7'd4, LS_EMPTY, LS_EMPTY);
    issue_req(b, OP_READ, 7'd4, LS_EMPTY, LS_EMPTY);
    issue_req(b, OP_WRITE, 7'd6, LS_EMPTY, LS_EMPTY);
    issue_req(b, OP_WRITE, 7'd7, LS_EMPTY, LS_EMPTY);
    // only offset 1 refilled since the other half is dirty
    issue_req(b, OP_READ_LINEFILL, 7'd7, LS_DIRTY, LS_SYNC);
    issue_req(b, OP_READ, 7'd7, LS_EMPTY, LS_EMPTY);
    issue_req(b, OP_READ, 7'd6, LS_EMPTY, LS_EMPTY);
    // both halves written since the other half is empty
    issue_req(b, OP_READ_LINEFILL, 7'd8, LS_SYNC, LS_EMPTY);
    issue_req(b, OP_READ, 7'd8, LS_EMPTY, LS_EMPTY);
    issue_req(b, OP_READ, 7'd9, LS_EMPTY, LS_EMPTY);
  endtask

  task automatic random_seq(input int b);
    for (int i = 0; i < 16; i++) begin
      issue_req(b, OP_WRITE, set_way_off_t'(i), LS_EMPTY, LS_EMPTY);
    end
    for (int i = 0; i < 40; i++) begin
      issue_req(b, opcode_t'({$random(seed)} % 3), set_way_off_t'({$random(seed)} % 16),
                line_state_t'({$random(seed)} % 3), line_state_t'({$random(seed)} % 3));
    end
  endtask

  // --------------------------------------------------
  // write buffer models sample the request at the edge
  // --------------------------------------------------
  always @(posedge clk) begin
    wb_seen[0] <= wb_req_valid[0];
    wb_seen[1] <= wb_req_valid[1];
  end

  always @(negedge clk) begin
    for (int b = 0; b < 2; b++) begin
      case (wb_state[b])
        0: begin
          wb_rtn_valid[b] = 1'b0;
          if (wb_seen[b] && !rst) begin
            if (wb_cnt[b] == 0) begin
              wb_req_ready[b] = 1'b1;
              wb_id[b]        = wb_req_id[b];
              assert (wb_req_ch[b] == req_ch[b] && wb_req_id[b] == req_wbid[b]) else begin
                $display("** Error @%0t: bank %0d wbuf ch %0d id %h, expected ch %0d id %h",
                         $time, b, wb_req_ch[b], wb_req_id[b], req_ch[b], req_wbid[b]);
                err_cnt++;
              end
              wb_cnt[b]       = {$random(seed)} % 4;
              wb_state[b]     = 1;
            end else begin
              wb_cnt[b]--;
            end
          end
        end
        1: begin
          wb_req_ready[b] = 1'b0;
          if (wb_cnt[b] == 0) begin
            wb_rtn_valid[b] = 1'b1;
            wb_rtn_data[b]  = {16{wb_id[b]}};
            wb_state[b]     = 2;
          end else begin
            wb_cnt[b]--;
          end
        end
        default: begin
          wb_rtn_valid[b] = 1'b0;
          wb_cnt[b]       = {$random(seed)} % 4;
          wb_state[b]     = 0;
        end
      endcase
    end
    // random back-pressure
    xbar_ready = ({$random(seed)} % 4) != 0;
  end

  // --------------------------------------------------
  // response monitor
  // --------------------------------------------------
  task automatic check_rsp(input bank_t b, input logic [132:0] got);
    logic [132:0] exp;
    assert (exp_q[b].size() != 0) else begin
      $display("** Error @%0t: bank %0d response with nothing expected", $time, b);
      err_cnt++;
    end
    if (exp_q[b].size() != 0) begin
      exp = exp_q[b].pop_front();
      assert (got == exp) else begin
        $display("** Error @%0t: bank %0d got ch %0d rob %0d data %h, exp ch %0d rob %0d data %h",
                 $time, b, got[132:131], got[130:128], got[127:0],
                 exp[132:131], exp[130:128], exp[127:0]);
        err_cnt++;
      end
    end
    rsp_cnt++;
  endtask

  always @(posedge clk) begin
    if (!rst && xbar_valid && xbar_ready) begin
      check_rsp(xbar_bank, {xbar_ch, xbar_rob, xbar_data});
    end
  end

  initial begin
    rst = 1'b1;
    xbar_ready = 1'b0;
    for (int b = 0; b < 2; b++) begin
      req_valid[b] = 1'b0;
      req_op[b] = OP_READ;
      req_ch[b] = '0;
      req_idx[b] = '0;
      req_wbid[b] = '0;
      req_rob[b] = '0;
      req_s0[b] = LS_EMPTY;
      req_s1[b] = LS_EMPTY;
      req_f0[b] = '0;
      req_f1[b] = '0;
      wb_req_ready[b] = 1'b0;
      wb_rtn_valid[b] = 1'b0;
      wb_rtn_data[b] = '0;
      wb_state[b] = 0;
      wb_cnt[b] = 0;
      wb_id[b] = '0;
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    repeat (5) @(posedge clk);
    fork
      directed_seq(0);
      directed_seq(1);
    join
    fork
      random_seq(0);
      random_seq(1);
    join
    for (int b = 0; b < 2; b++) begin
      assert (exp_q[b].size() == 0) else begin
        $display("** Error @%0t: bank %0d has %0d responses missing", $time, b,
                 exp_q[b].size());
        err_cnt++;
      end
    end
    $display("responses: %0d, data errors: %0d, timeouts: %0d, checker failures: %0d",
             rsp_cnt, err_cnt, tmo_cnt, l2_data_banks_inst.l2_data_chk_inst.fail_cnt);
    if (err_cnt == 0 && tmo_cnt == 0 && l2_data_banks_inst.l2_data_chk_inst.fail_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
